/* Makefile */
TOP = mcu4_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f compile.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "Test OK" $(LOG) || (echo "No pass message in log"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* compile.f */
design/mcu4_pkg.sv
design/wb_master.sv
design/pc_unit.sv
design/stack_unit.sv
design/irq_unit.sv
design/sequencer.sv
design/mcu4_top.sv
tb/mcu4_assertions.sv
tb/mcu4_tb.sv

/* design/irq_unit.sv */
module irq_unit (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] k0,
    input  logic [3:0] k0_mask,
    input  logic       ei,
    input  logic       irq_take,
    input  logic       pset_seen,
    output logic       irq_pending,
    output logic       irq_ack
);

    logic [3:0] k0_s1;
    logic [3:0] k0_s2;
    logic [3:0] k0_rise;
    logic       req_q;  // K0 factor flag
    logic       ie_q;   // Interrupt enable flag
    logic       ack_q;

    assign k0_rise = k0_s1 & ~k0_s2 & k0_mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            k0_s1 <= 4'h0;
            k0_s2 <= 4'h0;
            req_q <= 1'b0;
            ie_q  <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            k0_s1 <= k0;     // Pins are asynchronous
            k0_s2 <= k0_s1;
            // A new edge in the take cycle is kept
            req_q <= (req_q && !irq_take) || (|k0_rise);
            if (irq_take) begin
                ie_q <= 1'b0;
            end else if (ei) begin
                ie_q <= 1'b1;
            end
            ack_q <= irq_take;
        end
    end

    // Held off while a PSET is the current instruction
    assign irq_pending = req_q && ie_q && !pset_seen;
    assign irq_ack     = ack_q;

endmodule

/* design/mcu4_pkg.sv */
package mcu4_pkg;

    typedef logic [11:0] instr_t;
    typedef logic [12:0] pc_t;      // Bank, page, step
    typedef logic [4:0]  np_t;      // Bank and page
    typedef logic [3:0]  nibble_t;
    typedef logic [7:0]  sp_t;
    typedef logic [13:0] bus_adr_t; // Bit 13 selects data RAM

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        bus_adr_t adr;
        instr_t   wdat;
    } wb_req_t;

    typedef struct packed {
        logic   ack;
        instr_t rdat;
    } wb_rsp_t;

    typedef enum logic [2:0] {
        FETCH,
        WAIT_FETCH,
        DECODE,
        PUSH,
        POP,
        VECTOR
    } seq_state_t;

    // Opcode match values and masks
    localparam instr_t OP_JP        = 12'h000;
    localparam instr_t OP_JP_MASK   = 12'hF00;
    localparam instr_t OP_PSET      = 12'hE40; // Low five bits carry the new page
    localparam instr_t OP_PSET_MASK = 12'hFE0;
    localparam instr_t OP_NOP5      = 12'hFFB;
    localparam instr_t OP_EI        = 12'hF41;
    localparam instr_t OP_RET       = 12'hFDF;

    localparam pc_t IRQ_VECTOR = 13'h0102; // K0 interrupt entry

endpackage

/* design/mcu4_top.sv */
module mcu4_top #(
    parameter mcu4_pkg::pc_t RESET_PC = 13'h0100,
    parameter mcu4_pkg::sp_t RESET_SP = 8'h00
) (
    input  logic              clk,
    input  logic              rst,
    output mcu4_pkg::wb_req_t wb_req,
    input  mcu4_pkg::wb_rsp_t wb_rsp,
    input  logic [3:0]        k0,
    input  logic [3:0]        k0_mask,
    output logic              irq_ack
);
    import mcu4_pkg::*;

    logic       bus_go;
    logic       bus_we;
    bus_adr_t   bus_adr;
    instr_t     bus_wdat;
    logic       bus_done;
    instr_t     bus_rdat;
    instr_t     instr;
    pc_t        pc;
    bus_adr_t   ram_adr;
    logic       pc_inc;
    logic       pc_jump;
    logic       pc_pset;
    logic       pc_vector;
    logic [1:0] pc_load_nib;
    logic       np_reload;
    logic       sp_push;
    logic       sp_pop;
    logic       irq_take;
    logic       ei;
    logic       pset_seen;
    logic       irq_pending;

    sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .bus_done    (bus_done),
        .bus_rdat    (bus_rdat),
        .bus_go      (bus_go),
        .bus_we      (bus_we),
        .bus_adr     (bus_adr),
        .bus_wdat    (bus_wdat),
        .pc          (pc),
        .ram_adr     (ram_adr),
        .irq_pending (irq_pending),
        .pc_inc      (pc_inc),
        .pc_jump     (pc_jump),
        .pc_pset     (pc_pset),
        .pc_vector   (pc_vector),
        .pc_load_nib (pc_load_nib),
        .np_reload   (np_reload),
        .sp_push     (sp_push),
        .sp_pop      (sp_pop),
        .irq_take    (irq_take),
        .ei          (ei),
        .pset_seen   (pset_seen),
        .instr       (instr)
    );

    wb_master u_wb (
        .clk      (clk),
        .rst      (rst),
        .bus_go   (bus_go),
        .bus_we   (bus_we),
        .bus_adr  (bus_adr),
        .bus_wdat (bus_wdat),
        .bus_done (bus_done),
        .bus_rdat (bus_rdat),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp)
    );

    // RET data arrives in the low nibble of the read word
    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clk         (clk),
        .rst         (rst),
        .pc_inc      (pc_inc),
        .pc_jump     (pc_jump),
        .pc_pset     (pc_pset),
        .pc_vector   (pc_vector),
        .np_reload   (np_reload),
        .pc_load_nib (pc_load_nib),
        .instr       (instr),
        .nib_in      (bus_rdat[3:0]),
        .pc          (pc),
        .np          ()
    );

    stack_unit #(
        .RESET_SP (RESET_SP)
    ) u_stack (
        .clk     (clk),
        .rst     (rst),
        .sp_push (sp_push),
        .sp_pop  (sp_pop),
        .sp      (),
        .ram_adr (ram_adr)
    );

    irq_unit u_irq (
        .clk         (clk),
        .rst         (rst),
        .k0          (k0),
        .k0_mask     (k0_mask),
        .ei          (ei),
        .irq_take    (irq_take),
        .pset_seen   (pset_seen),
        .irq_pending (irq_pending),
        .irq_ack     (irq_ack)
    );

endmodule

/* design/pc_unit.sv */
module pc_unit #(
    parameter mcu4_pkg::pc_t RESET_PC = 13'h0100
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pc_inc,
    input  logic              pc_jump,
    input  logic              pc_pset,
    input  logic              pc_vector,
    input  logic              np_reload,
    input  logic [1:0]        pc_load_nib,
    input  mcu4_pkg::instr_t  instr,
    input  mcu4_pkg::nibble_t nib_in,
    output mcu4_pkg::pc_t     pc,
    output mcu4_pkg::np_t     np
);
    import mcu4_pkg::*;

    pc_t pc_q;
    pc_t pc_next;
    np_t np_q;
    np_t np_next;

    always_comb begin
        pc_next = pc_q;
        if (pc_vector) begin
            pc_next = IRQ_VECTOR;
        end else if (pc_jump) begin
            pc_next = {np_q, instr[7:0]}; // Page from NP, step from opcode
        end else if (pc_inc) begin
            pc_next = pc_q + 13'd1;
        end else begin
            // RET rebuilds PC one nibble at a time
            case (pc_load_nib)
                2'd1:    pc_next[3:0]  = nib_in;
                2'd2:    pc_next[7:4]  = nib_in;
                2'd3:    pc_next[12:8] = {1'b0, nib_in}; // Bank not on stack
                default: pc_next       = pc_q;
            endcase
        end
    end

    // NP follows the PC being written this cycle
    always_comb begin
        np_next = np_q;
        if (pc_pset) begin
            np_next = instr[4:0];
        end else if (np_reload) begin
            np_next = pc_next[12:8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
            np_q <= RESET_PC[12:8];
        end else begin
            pc_q <= pc_next;
            np_q <= np_next;
        end
    end

    assign pc = pc_q;
    assign np = np_q;

endmodule

/* design/sequencer.sv */
module sequencer (
    input  logic               clk,
    input  logic               rst,
    input  logic               bus_done,
    input  mcu4_pkg::instr_t   bus_rdat,
    output logic               bus_go,
    output logic               bus_we,
    output mcu4_pkg::bus_adr_t bus_adr,
    output mcu4_pkg::instr_t   bus_wdat,
    input  mcu4_pkg::pc_t      pc,
    input  mcu4_pkg::bus_adr_t ram_adr,
    input  logic               irq_pending,
    output logic               pc_inc,
    output logic               pc_jump,
    output logic               pc_pset,
    output logic               pc_vector,
    output logic [1:0]         pc_load_nib,
    output logic               np_reload,
    output logic               sp_push,
    output logic               sp_pop,
    output logic               irq_take,
    output logic               ei,
    output logic               pset_seen,
    output mcu4_pkg::instr_t   instr
);
    import mcu4_pkg::*;

    seq_state_t state_q;
    seq_state_t state_next;
    instr_t     instr_q;
    logic [1:0] nib_q;      // Which PC nibble is moving
    logic [1:0] nib_next;
    logic [1:0] phase_q;    // Sub-step of one stack transfer
    logic [1:0] phase_next;
    logic       nib_last;
    logic       is_jp;
    logic       is_pset;
    logic       is_ei;
    logic       is_ret;
    nibble_t    push_nib;

    assign is_jp    = (instr_q & OP_JP_MASK) == OP_JP;
    assign is_pset  = (instr_q & OP_PSET_MASK) == OP_PSET;
    assign is_ei    = instr_q == OP_EI;
    assign is_ret   = instr_q == OP_RET;
    assign nib_last = nib_q == 2'd2;

    // High page nibble goes first, to sp-1
    always_comb begin
        case (nib_q)
            2'd0:    push_nib = pc[11:8];
            2'd1:    push_nib = pc[7:4];
            default: push_nib = pc[3:0];
        endcase
    end

    always_comb begin
        state_next  = state_q;
        nib_next    = nib_q;
        phase_next  = phase_q;
        bus_go      = 1'b0;
        bus_we      = 1'b0;
        bus_adr     = {1'b0, pc}; // ROM side by default
        bus_wdat    = 12'h000;
        pc_inc      = 1'b0;
        pc_jump     = 1'b0;
        pc_pset     = 1'b0;
        pc_vector   = 1'b0;
        pc_load_nib = 2'd0;
        np_reload   = 1'b0;
        sp_push     = 1'b0;
        sp_pop      = 1'b0;
        irq_take    = 1'b0;
        ei          = 1'b0;

        case (state_q)
            FETCH: begin
                bus_go     = 1'b1;
                state_next = WAIT_FETCH;
            end
            WAIT_FETCH: begin
                if (bus_done) begin
                    pc_inc     = 1'b1;
                    state_next = DECODE;
                end
            end
            DECODE: begin
                nib_next   = 2'd0;
                phase_next = 2'd0;
                if (is_pset) begin
                    pc_pset    = 1'b1; // NP keeps the PSET value
                    state_next = FETCH;
                end else if (is_ret) begin
                    state_next = POP;
                end else begin
                    // JP, NOP5, EI and anything unimplemented
                    np_reload = 1'b1;
                    pc_jump   = is_jp;
                    ei        = is_ei;
                    if (irq_pending) begin
                        irq_take   = 1'b1;
                        state_next = PUSH;
                    end else begin
                        state_next = FETCH;
                    end
                end
            end
            PUSH: begin
                case (phase_q)
                    2'd0: begin
                        sp_push    = 1'b1;
                        phase_next = 2'd1;
                    end
                    2'd1: begin
                        bus_go     = 1'b1;
                        bus_we     = 1'b1;
                        bus_adr    = ram_adr;
                        bus_wdat   = {8'h00, push_nib};
                        phase_next = 2'd2;
                    end
                    default: begin
                        if (bus_done) begin
                            phase_next = 2'd0;
                            if (nib_last) begin
                                state_next = VECTOR;
                            end else begin
                                nib_next = nib_q + 2'd1;
                            end
                        end
                    end
                endcase
            end
            POP: begin
                if (phase_q == 2'd0) begin
                    bus_go     = 1'b1;
                    bus_adr    = ram_adr;
                    phase_next = 2'd1;
                end else if (bus_done) begin
                    sp_pop      = 1'b1;
                    pc_load_nib = nib_q + 2'd1; // Step low, step high, page
                    phase_next  = 2'd0;
                    if (nib_last) begin
                        np_reload  = 1'b1;
                        state_next = FETCH;
                    end else begin
                        nib_next = nib_q + 2'd1;
                    end
                end
            end
            VECTOR: begin
                pc_vector  = 1'b1;
                np_reload  = 1'b1;
                state_next = FETCH;
            end
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FETCH;
            nib_q   <= 2'd0;
            phase_q <= 2'd0;
            instr_q <= OP_NOP5; // Harmless until the first fetch lands
        end else begin
            state_q <= state_next;
            nib_q   <= nib_next;
            phase_q <= phase_next;
            if (state_q == WAIT_FETCH && bus_done) begin
                instr_q <= bus_rdat;
            end
        end
    end

    assign pset_seen = is_pset;
    assign instr     = instr_q;

endmodule

/* design/stack_unit.sv */
module stack_unit #(
    parameter mcu4_pkg::sp_t RESET_SP = 8'h00
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               sp_push,
    input  logic               sp_pop,
    output mcu4_pkg::sp_t      sp,
    output mcu4_pkg::bus_adr_t ram_adr
);
    import mcu4_pkg::*;

    sp_t sp_q;

    // Pre-decrement on push, post-increment on pop
    always_ff @(posedge clk) begin
        if (rst) begin
            sp_q <= RESET_SP;
        end else if (sp_push) begin
            sp_q <= sp_q - 8'd1;
        end else if (sp_pop) begin
            sp_q <= sp_q + 8'd1;
        end
    end

    // Stack lives at the bottom of data space
    assign ram_adr = {1'b1, 5'b00000, sp_q};
    assign sp      = sp_q;

endmodule

/* design/wb_master.sv */
module wb_master (
    input  logic               clk,
    input  logic               rst,
    input  logic               bus_go,
    input  logic               bus_we,
    input  mcu4_pkg::bus_adr_t bus_adr,
    input  mcu4_pkg::instr_t   bus_wdat,
    output logic               bus_done,
    output mcu4_pkg::instr_t   bus_rdat,
    output mcu4_pkg::wb_req_t  wb_req,
    input  mcu4_pkg::wb_rsp_t  wb_rsp
);
    import mcu4_pkg::*;

    logic     cyc_q;
    logic     we_q;
    logic     done_q;
    bus_adr_t adr_q;
    instr_t   wdat_q;
    instr_t   rdat_q;
    logic     ack_seen;
    logic     start;

    assign ack_seen = cyc_q && wb_rsp.ack;
    assign start    = bus_go && !cyc_q; // Requests only accepted while idle

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q  <= 1'b0;
            we_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= ack_seen;
            if (ack_seen) begin
                cyc_q <= 1'b0; // Close after the single transfer
                we_q  <= 1'b0;
            end else if (start) begin
                cyc_q <= 1'b1;
                we_q  <= bus_we;
            end
        end
    end

    // Address and write data held for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q  <= bus_adr;
            wdat_q <= bus_wdat;
        end
        if (ack_seen && !we_q) begin
            rdat_q <= wb_rsp.rdat;
        end
    end

    // Classic cycle, stb follows cyc
    assign wb_req = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, wdat: wdat_q};

    assign bus_done = done_q;
    assign bus_rdat = rdat_q;

endmodule

/* tb/mcu4_assertions.sv */
module mcu4_assertions (
    input logic              clk,
    input logic              rst,
    input mcu4_pkg::wb_req_t wb_req,
    input mcu4_pkg::wb_rsp_t wb_rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    // One transfer per cycle, closed right after the ack
    cyc_ends_on_ack: assert property (@(posedge clk) disable iff (rst)
        (wb_req.cyc && wb_rsp.ack) |=> !wb_req.cyc)
        else $error("cyc still high after ack");

    // Request held until the slave acks
    adr_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req.adr) && wb_req.stb)
        else $error("bus address changed before ack");

    wdat_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_req.stb && wb_req.we && !wb_rsp.ack) |=> $stable(wb_req.wdat))
        else $error("write data changed before ack");

    cyc_after_rst: assert property (@(posedge clk)
        rst |=> !wb_req.cyc)
        else $error("cyc not low after reset");

endmodule

bind wb_master mcu4_assertions u_wb_assert (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
);

/* tb/mcu4_tb.sv */
module mcu4_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mcu4_pkg::*;

    // 24 fetches at no more than about 15 cycles each, plus a wide margin
    localparam int MAX_CYCLES = 4000;
    localparam int LAST_FETCH = 24;

    logic       clk;
    logic       rst;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic [3:0] k0;
    logic [3:0] k0_mask;
    logic       irq_ack;

    instr_t      rom [0:8191];
    nibble_t     ram [0:255];
    logic        busy;
    int unsigned wait_cnt;

    // Reference model state
    pc_t     exp_fetch;
    np_t     model_np;
    sp_t     model_sp;
    logic    model_ie;
    logic    model_req;
    pc_t     ret_pc;
    nibble_t push_q[$];
    int      push_left;
    int      pop_left;
    int      fetch_cnt;
    int      irq_expected;
    int      irq_seen;
    int      k0_hold;
    int      cycle_cnt;

    mcu4_top #(
        .RESET_PC (13'h0100),
        .RESET_SP (8'h00)
    ) UUT (
        .clk     (clk),
        .rst     (rst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .k0      (k0),
        .k0_mask (k0_mask),
        .irq_ack (irq_ack)
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("Mismatch %s expected %h actual %h", name, exp_v, act_v);
            stop_run("Compare failed");
        end
    endtask

    function automatic logic is_pset(input instr_t ins);
        return ins[11:5] == 7'b1110010; // E4x and E5x
    endfunction

    // JP takes the page from NP, everything else steps on
    function automatic pc_t next_fetch(input instr_t ins, input pc_t cur_pc, input np_t cur_np);
        if (ins[11:8] == 4'h0) begin
            return {cur_np, ins[7:0]};
        end
        return cur_pc + 13'd1;
    endfunction

    task automatic pulse_k0(input logic [3:0] bits);
        k0      <= bits;
        k0_hold = 3;
        if (|(bits & k0_mask)) begin
            model_req = 1'b1; // Latched only on an unmasked bit
        end
    endtask

    // Wishbone slave with a random wait of 0 to 3 cycles
    always @(posedge clk) begin
        if (rst) begin
            wb_rsp.ack <= 1'b0;
            busy = 1'b0;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack <= 1'b0;
            busy = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!busy) begin
                busy = 1'b1;
                wait_cnt = $urandom % 4;
            end
            if (wait_cnt == 0) begin
                wb_rsp.ack <= 1'b1;
                if (wb_req.adr[13]) begin
                    if (wb_req.we) begin
                        ram[wb_req.adr[7:0]] <= wb_req.wdat[3:0];
                    end
                    wb_rsp.rdat <= {8'h00, ram[wb_req.adr[7:0]]};
                end else begin
                    wb_rsp.rdat <= rom[wb_req.adr[12:0]];
                end
            end else begin
                wait_cnt--;
            end
        end
    end

    // Monitor and compare, also drives the K0 pulses
    always @(posedge clk) begin
        instr_t ins;
        pc_t    nxt;
        logic   take;
        if (k0_hold > 0) begin
            k0_hold--;
            if (k0_hold == 0) k0 <= 4'h0;
        end
        if (irq_ack) irq_seen++;
        if (!rst && wb_req.cyc && wb_rsp.ack) begin
            if (wb_req.we) begin
                if (push_left == 0) stop_run("Data write without an interrupt entry");
                check_value("push address", {1'b1, 5'b00000, model_sp - 8'd1}, wb_req.adr);
                check_value("push data", push_q.pop_front(), wb_req.wdat);
                model_sp--;
                push_left--;
                if (push_left == 0) begin
                    exp_fetch = 13'h0102;
                    model_np  = 5'h01;
                end
            end else if (wb_req.adr[13]) begin
                if (pop_left == 0) stop_run("Data read outside of a RET");
                check_value("pop address", {1'b1, 5'b00000, model_sp}, wb_req.adr);
                case (pop_left)
                    3:       ret_pc[3:0]  = wb_rsp.rdat[3:0];
                    2:       ret_pc[7:4]  = wb_rsp.rdat[3:0];
                    default: ret_pc[12:8] = {1'b0, wb_rsp.rdat[3:0]}; // Bank comes back clear
                endcase
                model_sp++;
                pop_left--;
                if (pop_left == 0) begin
                    exp_fetch = ret_pc;
                    model_np  = ret_pc[12:8];
                end
            end else begin
                if (push_left != 0 || pop_left != 0) begin
                    stop_run("Instruction fetch in the middle of a stack transfer");
                end
                check_value("fetch", exp_fetch, wb_req.adr);
                ins = wb_rsp.rdat;
                fetch_cnt++;
                // Old flag value, so EI never takes its own interrupt
                take = model_ie && model_req && !is_pset(ins) && ins != 12'hFDF;
                nxt  = next_fetch(ins, exp_fetch, model_np);
                model_np = is_pset(ins) ? ins[4:0] : nxt[12:8];
                if (ins == 12'hF41) model_ie = 1'b1;
                if (ins == 12'hFDF) pop_left = 3;
                if (take) begin
                    model_ie  = 1'b0;
                    model_req = 1'b0;
                    push_left = 3;
                    push_q.push_back(nxt[11:8]);
                    push_q.push_back(nxt[7:4]);
                    push_q.push_back(nxt[3:0]);
                    irq_expected++;
                end
                exp_fetch = nxt;
                case (wb_req.adr[12:0])
                    13'h14A5: pulse_k0(4'b0010); // Masked bit while EI sets the flag
                    13'h14A6: pulse_k0(4'b0001); // Lands during the PSET
                    13'h0F31: pulse_k0(4'b0001); // Flag clear after entry
                    default: ;
                endcase
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) stop_run("Timeout, the program did not finish in time");
    end

    initial begin
        void'($urandom(32'h5a2686a2));
        clk = 1'b0;
        rst = 1'b1;
        k0 = 4'h0;
        k0_mask = 4'b0001;
        wb_rsp = '0;
        exp_fetch = 13'h0100;
        model_np = 5'h01;
        model_sp = 8'h00;
        model_ie = 1'b0;
        model_req = 1'b0;
        ret_pc = '0;
        push_left = 0;
        pop_left = 0;
        fetch_cnt = 0;
        irq_expected = 0;
        irq_seen = 0;
        k0_hold = 0;
        cycle_cnt = 0;
        for (int i = 0; i < 8192; i++) begin
            rom[i] = i[11:0] ^ {i[12], 11'b0};
        end
        for (int i = 0; i < 256; i++) begin
            ram[i] = i[3:0] ^ i[7:4];
        end
        rom[13'h0100] = 12'hE4F; // PSET 0F
        rom[13'h0101] = 12'h023; // JP to 0F23
        rom[13'h0F23] = 12'hE54; // PSET 14, bank 1
        rom[13'h0F24] = 12'h010; // JP to 1410
        rom[13'h1410] = 12'hE4F; // PSET 0F, dropped again by the NOP5
        rom[13'h1411] = 12'hFFB;
        rom[13'h1412] = 12'h0A5; // NP reloaded to 14
        rom[13'h14A5] = 12'hF41; // EI
        rom[13'h14A6] = 12'hFFB;
        rom[13'h14A7] = 12'hE5F; // PSET 1F
        rom[13'h14A8] = 12'h030; // Interrupt taken after this JP
        rom[13'h0102] = 12'hFDF; // Handler returns at once
        for (int i = 13'h0F30; i < 13'h0F35; i++) begin
            rom[i] = 12'hFFB;
        end
        rom[13'h0F35] = 12'h035; // Park loop
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        wait (fetch_cnt >= LAST_FETCH);
        repeat (2) @(posedge clk);
        check_value("irq_ack count", irq_expected, irq_seen);
        check_value("interrupt entries", 1, irq_expected);
        $display("Test OK");
        $finish;
    end

endmodule
